/* Makefile */
# tool and build settings, each can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(wildcard verilog/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
verilog/rv_core_pkg.sv
verilog/dec_bus_if.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/core_ctrl.sv
verilog/exec_unit.sv
verilog/rv_core_top.sv
sim/rv_core_assertions.sv
sim/tb_rv_core.sv

/* sim/rv_core_assertions.sv */
`timescale 1ns/1ns

module rv_core_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         inst_req,
    input logic                         inst_ack,
    input logic [rv_core_pkg::xlen-1:0] inst_addr,
    input logic                         halted
);

    // req drops only after an ack was seen
    a_req_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(inst_req) |-> $past(inst_ack))
        else $error("inst_req fell without inst_ack");

    // new request only once ack is low again
    a_req_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(inst_req) |-> !$past(inst_ack))
        else $error("inst_req rose while inst_ack was high");

    // address held for the whole request
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (inst_req && $past(inst_req)) |-> $stable(inst_addr))
        else $error("inst_addr changed while inst_req was high");

    // parked after a halt
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halted |-> !inst_req)
        else $error("inst_req high while halted");

endmodule

bind core_ctrl rv_core_assertions u_fetch_assert (
    .clk       (clk),
    .rst       (rst),
    .inst_req  (inst_req),
    .inst_ack  (inst_ack),
    .inst_addr (inst_addr),
    .halted    (halted)
);

/* sim/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;
    import rv_core_pkg::*;

    // system words used by the programs
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [31:0] ecall_word = 32'h0000_0073;
    // sw x1, 0(x2), the core has no store path
    localparam logic [31:0] store_word = 32'h0011_2023;

    logic                 clk;
    logic                 rst;
    logic                 inst_req;
    logic [xlen-1:0]      inst_addr;
    logic                 inst_ack;
    logic [xlen-1:0]      inst_data;
    logic                 halted;
    halt_cause_e          halt_cause;
    logic [reg_idx_w-1:0] dbg_addr;
    logic [xlen-1:0]      dbg_data;

    // instruction memory, saved I program, model registers
    logic [xlen-1:0] prog [64];
    logic [xlen-1:0] i_prog [64];
    logic [xlen-1:0] ref_regs [32];
    logic [31:0]     lfsr_state;
    int              errors;
    int              checks;
    int              tests;
    int              fetches;

    rv_core_top dut (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_ack   (inst_ack),
        .inst_data  (inst_data),
        .halted     (halted),
        .halt_cause (halt_cause),
        .dbg_addr   (dbg_addr),
        .dbg_data   (dbg_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // op-imm encoder
    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // add or sub encoder
    function automatic logic [31:0] enc_r(input logic sub, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        return {1'b0, sub, 5'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    // unused words decode illegal and carry their own index
    task automatic clear_prog();
        for (int i = 0; i < 64; i++) begin
            prog[i] = {24'(i), 8'hff};
        end
    endtask

    // ISA-level model, returns the number of fetches up to the halt
    function automatic int model_program();
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        for (int idx = 0; idx < 64; idx++) begin
            w = prog[idx];
            a = ref_regs[w[19:15]];
            b = ref_regs[w[24:20]];
            imm = {{20{w[31]}}, w[31:20]};
            case (w[6:0])
                7'b0010011: begin
                    case (w[14:12])
                        3'b000: res = a + imm;
                        3'b011: res = {31'd0, a < imm};
                        3'b101: res = $signed(a) >>> w[24:20];
                        default: res = a & imm;
                    endcase
                end
                7'b0110011: res = w[30] ? a - b : a + b;
                7'b0110111: res = {w[31:12], 12'h000};
                7'b0010111: res = {w[31:12], 12'h000} + 32'(idx * 4);
                // ecall, ebreak or illegal all stop here
                default: return idx + 1;
            endcase
            if (w[11:7] != 5'd0) ref_regs[w[11:7]] = res;
        end
        return 64;
    endfunction

    task automatic check_word(input string name, input logic [xlen-1:0] got,
                              input logic [xlen-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cause(input string name, input halt_cause_e got,
                               input halt_cause_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) $display("test %s done, no errors", name);
        else $display("test %s done, %0d errors", name, errors - err0);
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        next_cycle();
        rst = 1'b1;
        inst_ack = 1'b0;
        inst_data = '0;
        repeat (5) next_cycle();
        rst = 1'b0;
    endtask

    // combinational debug read, one register per cycle
    task automatic read_reg(input int idx, output logic [xlen-1:0] val);
        next_cycle();
        dbg_addr = 5'(idx);
        #1;
        val = dbg_data;
    endtask

    task automatic check_regs();
        logic [xlen-1:0] val;
        for (int i = 0; i < 32; i++) begin
            read_reg(i, val);
            check_word($sformatf("x%0d", i), val, ref_regs[i]);
        end
    endtask

    // four-phase responder, runs until the core halts
    task automatic serve_fetches(input bit rand_delays);
        int          ack_dly;
        int          drop_dly;
        int          t;
        logic [31:0] exp_addr;
        fetches = 0;
        exp_addr = '0;
        while (!halted && fetches < 64) begin
            t = 0;
            while (!inst_req && !halted && t < 50) begin
                next_cycle();
                t++;
            end
            if (halted) break;
            if (!inst_req) begin
                report_error("core never raised inst_req");
                break;
            end
            // addresses must step by 4 in order
            check_word("inst_addr", inst_addr, exp_addr);
            ack_dly = rand_delays ? int'(rand_bits(3)) : 0;
            drop_dly = rand_delays ? int'(rand_bits(3)) : 0;
            repeat (ack_dly) next_cycle();
            inst_ack = 1'b1;
            inst_data = prog[inst_addr[7:2]];
            t = 0;
            while (inst_req && t < 50) begin
                next_cycle();
                t++;
            end
            if (inst_req) begin
                report_error("core kept inst_req high after inst_ack");
                break;
            end
            repeat (drop_dly) next_cycle();
            inst_ack = 1'b0;
            fetches++;
            exp_addr += 4;
        end
    endtask

    task automatic wait_halt();
        int t;
        t = 0;
        while (!halted && t < 40) begin
            next_cycle();
            t++;
        end
        if (!halted) report_error("core did not halt");
    endtask

    // no fetch may follow a halt
    task automatic check_no_fetch(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_bit("inst_req", inst_req, 1'b0);
        end
    endtask

    task automatic run_and_check(input bit rand_delays, input halt_cause_e exp_cause);
        int n_model;
        apply_reset();
        serve_fetches(rand_delays);
        wait_halt();
        n_model = model_program();
        check_cause("halt_cause", halt_cause, exp_cause);
        check_word("fetch count", 32'(fetches), 32'(n_model));
        check_regs();
    endtask

    task automatic test_reset();
        int err0;
        err0 = errors;
        apply_reset();
        check_bit("inst_req", inst_req, 1'b0);
        check_bit("halted", halted, 1'b0);
        check_cause("halt_cause", halt_cause, cause_none);
        // first request exactly one cycle after reset falls
        next_cycle();
        check_bit("inst_req", inst_req, 1'b1);
        check_word("inst_addr", inst_addr, '0);
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        check_regs();
        finish_test("reset", err0);
    endtask

    task automatic build_i_prog();
        logic [1:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [11:0] imm;
        clear_prog();
        for (int k = 0; k < 24; k++) begin
            op = 2'(rand_bits(2));
            rd = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            imm = 12'(rand_bits(12));
            // seed some registers from x0 first
            if (k < 6) begin
                op = 2'd0;
                rs1 = 5'd0;
            end
            case (op)
                2'd0: prog[k] = enc_i(3'b000, rd, rs1, imm);
                2'd1: prog[k] = enc_i(3'b011, rd, rs1, imm);
                2'd2: prog[k] = enc_i(3'b101, rd, rs1, {7'b0100000, imm[4:0]});
                default: prog[k] = enc_i(3'b111, rd, rs1, imm);
            endcase
        end
        prog[24] = ebreak_word;
    endtask

    task automatic test_i_kind();
        int err0;
        err0 = errors;
        build_i_prog();
        i_prog = prog;
        run_and_check(1'b0, cause_ebreak);
        finish_test("i_kind", err0);
    endtask

    task automatic test_r_kind();
        int          err0;
        logic        sub;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        err0 = errors;
        clear_prog();
        for (int k = 0; k < 7; k++) begin
            prog[k] = enc_i(3'b000, 5'(k + 1), 5'd0, 12'(rand_bits(12)));
        end
        // add and sub over x0..x7
        for (int k = 7; k < 19; k++) begin
            sub = rand_bits(1) != 0;
            rd = 5'(rand_bits(3));
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            prog[k] = enc_r(sub, rd, rs1, rs2);
        end
        // forced writes to x0
        prog[12] = enc_r(1'b0, 5'd0, 5'd1, 5'd2);
        prog[15] = enc_r(1'b1, 5'd0, 5'd3, 5'd4);
        prog[19] = ebreak_word;
        run_and_check(1'b0, cause_ebreak);
        finish_test("r_kind", err0);
    endtask

    task automatic test_u_kind();
        int              err0;
        logic [19:0]     uimm [8];
        logic [xlen-1:0] val;
        logic [xlen-1:0] exp;
        err0 = errors;
        clear_prog();
        // even slots lui, odd slots auipc, rd = slot + 1
        for (int k = 0; k < 8; k++) begin
            uimm[k] = 20'(rand_bits(20));
            prog[k] = {uimm[k], 5'(k + 1), (k % 2 == 1) ? 7'b0010111 : 7'b0110111};
        end
        prog[8] = ebreak_word;
        apply_reset();
        serve_fetches(1'b0);
        wait_halt();
        for (int k = 0; k < 8; k++) begin
            exp = {uimm[k], 12'h000} + ((k % 2 == 1) ? 32'(k * 4) : 32'd0);
            read_reg(k + 1, val);
            check_word($sformatf("x%0d", k + 1), val, exp);
        end
        finish_test("u_kind", err0);
    endtask

    task automatic test_halts();
        int          err0;
        halt_cause_e causes [3];
        logic [31:0] words [3];
        err0 = errors;
        causes = '{cause_ebreak, cause_ecall, cause_illegal};
        words = '{ebreak_word, ecall_word, store_word};
        for (int i = 0; i < 3; i++) begin
            clear_prog();
            prog[0] = enc_i(3'b000, 5'd5, 5'd0, 12'd123);
            prog[1] = enc_i(3'b000, 5'd6, 5'd0, 12'hff9);
            prog[2] = words[i];
            // never executed
            prog[3] = enc_i(3'b000, 5'd7, 5'd0, 12'd1);
            run_and_check(1'b0, causes[i]);
            check_bit("halted", halted, 1'b1);
            check_no_fetch(20);
            check_regs();
        end
        finish_test("halts", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        err0 = errors;
        prog = i_prog;
        repeat (2) run_and_check(1'b1, cause_ebreak);
        finish_test("backpressure", err0);
    endtask

    initial begin
        rst = 1'b1;
        inst_ack = 1'b0;
        inst_data = '0;
        dbg_addr = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        fetches = 0;
        lfsr_state = 32'd95958;
        test_reset();
        test_i_kind();
        test_r_kind();
        test_u_kind();
        test_halts();
        test_backpressure();
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verilog/core_ctrl.sv */
`timescale 1ns/1ns

module core_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    output logic                         inst_req,
    output logic [rv_core_pkg::xlen-1:0] inst_addr,
    input  logic                         inst_ack,
    input  logic [rv_core_pkg::xlen-1:0] inst_data,
    dec_bus_if.ctrl                      dec,
    output logic [rv_core_pkg::xlen-1:0] ir,
    output logic [rv_core_pkg::xlen-1:0] pc,
    output logic                         exec_en,
    output logic                         halted,
    output rv_core_pkg::halt_cause_e     halt_cause
);
    import rv_core_pkg::*;

    ctrl_state_e state;
    logic        req_q;
    logic        stop;

    // N kind and anything undecodable end the run
    assign stop = (dec.kind == kind_n) || (dec.kind == kind_bad);

    assign inst_req = req_q;
    // address is the pc, stable for the whole request
    assign inst_addr = pc;
    // one strobe per instruction
    assign exec_en = (state == st_exec);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_req;
            req_q <= 1'b0;
            pc <= '0;
            halted <= 1'b0;
            halt_cause <= cause_none;
        end else begin
            case (state)
                st_req: begin
                    if (!req_q) begin
                        // first request after reset
                        req_q <= 1'b1;
                    end else if (inst_ack) begin
                        // data captured, drop req on this edge
                        req_q <= 1'b0;
                        state <= st_wait_drop;
                    end
                end
                st_wait_drop: begin
                    // wait for the responder to release ack
                    if (!inst_ack) state <= st_exec;
                end
                st_exec: begin
                    if (stop) begin
                        state <= st_halt;
                        halted <= 1'b1;
                        if (dec.kind == kind_bad) halt_cause <= cause_illegal;
                        else if (dec.n_is_ebreak) halt_cause <= cause_ebreak;
                        else halt_cause <= cause_ecall;
                    end else begin
                        // next fetch goes out on the following cycle
                        pc <= pc + 32'd4;
                        req_q <= 1'b1;
                        state <= st_req;
                    end
                end
                st_halt: begin
                    // parked until reset
                    req_q <= 1'b0;
                end
                default: state <= st_halt;
            endcase
        end
    end

    // instruction register, loads on the ack edge only
    always_ff @(posedge clk) begin
        if (state == st_req && req_q && inst_ack) begin
            ir <= inst_data;
        end
    end

endmodule

/* verilog/dec_bus_if.sv */
`timescale 1ns/1ns

interface dec_bus_if;
    import rv_core_pkg::*;

    // decoded instruction class and operation
    inst_kind_e           kind;
    alu_op_e              alu_op;
    // register indices straight from the word
    logic [reg_idx_w-1:0] rd;
    logic [reg_idx_w-1:0] rs1;
    logic [reg_idx_w-1:0] rs2;
    // I or U immediate, already extended
    logic [xlen-1:0]      imm;
    // only meaningful when kind is kind_n
    logic                 n_is_ebreak;

    // decoder side
    modport drv (output kind, alu_op, rd, rs1, rs2, imm, n_is_ebreak);

    // sequencer needs the class and the halt flavour
    modport ctrl (input kind, n_is_ebreak);

    // execute side
    modport exe (input kind, alu_op, rd, imm);

endinterface

/* verilog/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
    input  logic                              exec_en,
    input  logic [rv_core_pkg::xlen-1:0]      pc,
    dec_bus_if.exe                            dec,
    input  logic [rv_core_pkg::xlen-1:0]      rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]      rs2_data,
    output logic                              wr_en,
    output logic [rv_core_pkg::reg_idx_w-1:0] wr_addr,
    output logic [rv_core_pkg::xlen-1:0]      wr_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] result;
    logic            writes_rd;

    assign op_a = rs1_data;
    // I kind takes the immediate as second operand
    assign op_b = (dec.kind == kind_i) ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            alu_add: result = op_a + op_b;
            alu_sub: result = op_a - op_b;
            // unsigned compare, immediate already sign extended
            alu_sltu: result = {{(xlen-1){1'b0}}, (op_a < op_b)};
            // shamt sits in imm bits 4:0
            alu_sra: result = $signed(op_a) >>> dec.imm[4:0];
            alu_and: result = op_a & op_b;
            alu_lui: result = dec.imm;
            alu_auipc: result = pc + dec.imm;
            default: result = '0;
        endcase
    end

    // only result-producing kinds touch the register file
    assign writes_rd = (dec.kind == kind_i) || (dec.kind == kind_u) ||
                       (dec.kind == kind_r);

    assign wr_en = exec_en && writes_rd;
    assign wr_addr = dec.rd;
    assign wr_data = result;

endmodule

/* verilog/inst_decode.sv */
`timescale 1ns/1ns

module inst_decode (
    input  logic [rv_core_pkg::xlen-1:0] inst,
    dec_bus_if.drv                       dec
);
    import rv_core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    inst_kind_e      kind;
    alu_op_e         alu_op;
    logic            n_is_ebreak;
    logic [xlen-1:0] imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // first the opcode class, then refine by funct fields
    always_comb begin
        kind = kind_bad;
        alu_op = alu_add;
        n_is_ebreak = 1'b0;
        case (opcode)
            opc_op_imm: begin
                kind = kind_i;
                case (funct3)
                    f3_add: alu_op = alu_add;
                    f3_sltu: alu_op = alu_sltu;
                    f3_and: alu_op = alu_and;
                    f3_sra: begin
                        alu_op = alu_sra;
                        // srli and other shift flavours are not supported
                        if (funct7 != f7_alt) kind = kind_bad;
                    end
                    default: kind = kind_bad;
                endcase
            end
            opc_op: begin
                kind = kind_r;
                if (funct3 != f3_add) kind = kind_bad;
                else if (funct7 == f7_base) alu_op = alu_add;
                else if (funct7 == f7_alt) alu_op = alu_sub;
                else kind = kind_bad;
            end
            opc_lui: begin
                kind = kind_u;
                alu_op = alu_lui;
            end
            opc_auipc: begin
                kind = kind_u;
                alu_op = alu_auipc;
            end
            opc_system: begin
                // only exact ecall or ebreak, csr ops fall to bad
                if (inst[31:7] == 25'd0) kind = kind_n;
                else if (inst[31:7] == ebreak_hi) begin
                    kind = kind_n;
                    n_is_ebreak = 1'b1;
                end
            end
            default: kind = kind_bad;
        endcase
    end

    // immediate picked by opcode, zero otherwise
    always_comb begin
        case (opcode)
            opc_op_imm: imm = {{20{inst[31]}}, inst[31:20]};
            opc_lui, opc_auipc: imm = {inst[31:12], 12'd0};
            default: imm = '0;
        endcase
    end

    assign dec.kind = kind;
    assign dec.alu_op = alu_op;
    assign dec.n_is_ebreak = n_is_ebreak;
    assign dec.imm = imm;
    // fixed field positions for all kinds
    assign dec.rd = inst[11:7];
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [rv_core_pkg::reg_idx_w-1:0] rs1,
    input  logic [rv_core_pkg::reg_idx_w-1:0] rs2,
    output logic [rv_core_pkg::xlen-1:0]      rs1_data,
    output logic [rv_core_pkg::xlen-1:0]      rs2_data,
    input  logic [rv_core_pkg::reg_idx_w-1:0] dbg_addr,
    output logic [rv_core_pkg::xlen-1:0]      dbg_data,
    input  logic                              wr_en,
    input  logic [rv_core_pkg::reg_idx_w-1:0] wr_addr,
    input  logic [rv_core_pkg::xlen-1:0]      wr_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0] regs [nregs];

    // x0 is hardwired to zero on every read port
    function automatic logic [xlen-1:0] read_port(input logic [reg_idx_w-1:0] addr);
        read_port = (addr == '0) ? '0 : regs[addr];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);
    assign dbg_data = read_port(dbg_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < nregs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* verilog/rv_core_pkg.sv */
package rv_core_pkg;

    // word and address width
    localparam int xlen = 32;
    // register index width and register count
    localparam int reg_idx_w = 5;
    localparam int nregs = 32;

    // major opcodes, bits 6:0
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // upper 25 bits of ebreak; ecall has all zeros there
    localparam logic [24:0] ebreak_hi = 25'b0000000000010000000000000;

    // funct3 values used by op-imm and op
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_sra = 3'b101;
    localparam logic [2:0] f3_and = 3'b111;

    // funct7 values, alt selects sub and srai
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt = 7'b0100000;

    // instruction kinds, same codes as the classic decoder key
    typedef enum logic [2:0] {
        kind_i   = 3'd0,
        kind_n   = 3'd1,
        kind_u   = 3'd2,
        kind_r   = 3'd3,
        kind_bad = 3'd7
    } inst_kind_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_sltu,
        alu_sra,
        alu_and,
        alu_lui,
        alu_auipc
    } alu_op_e;

    typedef enum logic [1:0] {st_req, st_wait_drop, st_exec, st_halt} ctrl_state_e;

    typedef enum logic [1:0] {cause_none, cause_ecall, cause_ebreak, cause_illegal} halt_cause_e;

endpackage

/* verilog/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst,
    output logic                              inst_req,
    output logic [rv_core_pkg::xlen-1:0]      inst_addr,
    input  logic                              inst_ack,
    input  logic [rv_core_pkg::xlen-1:0]      inst_data,
    output logic                              halted,
    output rv_core_pkg::halt_cause_e          halt_cause,
    input  logic [rv_core_pkg::reg_idx_w-1:0] dbg_addr,
    output logic [rv_core_pkg::xlen-1:0]      dbg_data
);
    import rv_core_pkg::*;

    logic [xlen-1:0]      ir;
    logic [xlen-1:0]      pc;
    logic                 exec_en;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_addr;
    logic [xlen-1:0]      wr_data;
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;

    dec_bus_if dec_bus ();

    // source indices go to the register file as plain wires
    assign rs1_idx = dec_bus.rs1;
    assign rs2_idx = dec_bus.rs2;

    inst_decode u_decode (
        .inst (ir),
        .dec  (dec_bus)
    );

    core_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_ack   (inst_ack),
        .inst_data  (inst_data),
        .dec        (dec_bus),
        .ir         (ir),
        .pc         (pc),
        .exec_en    (exec_en),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    exec_unit u_exec (
        .exec_en  (exec_en),
        .pc       (pc),
        .dec      (dec_bus),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1_idx),
        .rs2      (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

endmodule
